//--- hw/awb_pkg.sv
package awb_pkg;

    // channel width of one pixel component
    localparam int pix_w  = 8;
    // per-channel mean after the shift
    localparam int mean_w = 16;
    // gain word, low 8 bits are fraction
    localparam int gain_w = 24;

    // reset values, a mean of 1 over a mean of 1 gives unity gain
    localparam logic [mean_w-1:0] mean_one = mean_w'(1);
    localparam logic [gain_w-1:0] gain_one = gain_w'(256);

    // one rgb pixel
    typedef struct packed {
        logic [pix_w-1:0] r;
        logic [pix_w-1:0] g;
        logic [pix_w-1:0] b;
    } rgb_t;

    // video beat with syncs, travels through every stage
    typedef struct packed {
        logic vsync;
        logic hsync;
        logic den;
        rgb_t pix;
    } video_t;

    // frame statistics, stats to divider
    typedef struct packed {
        logic [mean_w-1:0] r;
        logic [mean_w-1:0] g;
        logic [mean_w-1:0] b;
    } means_t;

    // per-channel gains, divider to apply
    typedef struct packed {
        logic [gain_w-1:0] r;
        logic [gain_w-1:0] g;
        logic [gain_w-1:0] b;
    } gains_t;

endpackage

//--- hw/awb_stats.sv
module awb_stats import awb_pkg::*; #(
    parameter int stat_shift = 16
) (
    input  logic   clk,
    input  logic   reset_n,
    input  video_t vid_in,
    output video_t vid_s1,
    output logic   frame_start,
    output means_t means
);

    // nibble width taken from each channel
    localparam int nib_w = 4;
    // largest shifted sum that still leaves room for the plus one
    localparam logic [31:0] shifted_max = 32'((1 << mean_w) - 2);

    logic        vsync_rise;
    logic        vsync_fall;
    logic [31:0] sum_r;
    logic [31:0] sum_g;
    logic [31:0] sum_b;

    // plus one on every mean keeps the divisor nonzero
    function automatic logic [mean_w-1:0] to_mean(input logic [31:0] sum);
        logic [31:0] shifted;
        shifted = (sum >> stat_shift) + 32'd1;
        return shifted[mean_w-1:0];
    endfunction

    // upper nibble of a channel zero extended to the sum width
    function automatic logic [31:0] nibble(input logic [pix_w-1:0] c);
        return 32'(c[pix_w-1 -: nib_w]);
    endfunction

    // vid_s1 holds last cycle's vsync so edges come from it
    assign vsync_rise = vid_in.vsync & ~vid_s1.vsync;
    assign vsync_fall = ~vid_in.vsync & vid_s1.vsync;

    // first pipeline stage
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vid_s1 <= '0;
        end else begin
            vid_s1 <= vid_in;
        end
    end

    // start of frame pulse for the divider
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            frame_start <= 1'b0;
        end else begin
            frame_start <= vsync_rise;
        end
    end

    // accumulate active pixels and clear at frame start
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sum_r <= '0;
            sum_g <= '0;
            sum_b <= '0;
        end else if (vsync_rise) begin
            sum_r <= '0;
            sum_g <= '0;
            sum_b <= '0;
        end else if (vid_in.den) begin
            sum_r <= sum_r + nibble(vid_in.pix.r);
            sum_g <= sum_g + nibble(vid_in.pix.g);
            sum_b <= sum_b + nibble(vid_in.pix.b);
        end
    end

    // means held from one vsync fall to the next
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            means.r <= mean_one;
            means.g <= mean_one;
            means.b <= mean_one;
        end else if (vsync_fall) begin
            means.r <= to_mean(sum_r);
            means.g <= to_mean(sum_g);
            means.b <= to_mean(sum_b);
        end
    end

    // mean must fit mean_w bits or it wraps toward zero
    a_mean_fits: assert property (
        @(posedge clk) disable iff (!reset_n)
        vsync_fall |-> (sum_r >> stat_shift) <= shifted_max
                    && (sum_g >> stat_shift) <= shifted_max
                    && (sum_b >> stat_shift) <= shifted_max
    );

endmodule

//--- hw/awb_gain_divider.sv
module awb_gain_divider import awb_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  logic   frame_start,
    input  means_t means,
    output gains_t gains,
    output logic   gains_valid
);

    // one quotient bit per step
    localparam int div_steps = gain_w;

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_run,
        st_pub
    } state_t;

    state_t            state;
    logic [1:0]        ch;
    logic [4:0]        cnt;
    means_t            means_q;
    gains_t            acc;
    logic [mean_w-1:0] div_sel;
    logic [mean_w-1:0] divisor;
    logic [mean_w-1:0] rem;
    logic [gain_w-1:0] quo;
    logic [mean_w:0]   trial_in;
    logic [mean_w:0]   trial;
    logic [mean_w-1:0] rem_next;
    logic [gain_w-1:0] quo_next;

    // channel order r, g, b
    always_comb begin
        case (ch)
            2'd0:    div_sel = means_q.r;
            2'd1:    div_sel = means_q.g;
            default: div_sel = means_q.b;
        endcase
    end

    // one restoring step, shift in the next dividend bit
    always_comb begin
        trial_in = {rem, quo[gain_w-1]};
        trial    = trial_in - {1'b0, divisor};
        if (trial_in >= {1'b0, divisor}) begin
            rem_next = trial[mean_w-1:0];
            quo_next = {quo[gain_w-2:0], 1'b1};
        end else begin
            rem_next = trial_in[mean_w-1:0];
            quo_next = {quo[gain_w-2:0], 1'b0};
        end
    end

    // sequencer over the three channels
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state       <= st_idle;
            ch          <= '0;
            cnt         <= '0;
            gains.r     <= gain_one;
            gains.g     <= gain_one;
            gains.b     <= gain_one;
            gains_valid <= 1'b0;
        end else begin
            gains_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (frame_start) begin
                        ch    <= '0;
                        state <= st_load;
                    end
                end
                st_load: begin
                    cnt   <= '0;
                    state <= st_run;
                end
                st_run: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'(div_steps - 1)) begin
                        if (ch == 2'd2) begin
                            state <= st_pub;
                        end else begin
                            ch    <= ch + 2'd1;
                            state <= st_load;
                        end
                    end
                end
                default: begin
                    // all three gains switch together
                    gains       <= acc;
                    gains_valid <= 1'b1;
                    state       <= st_idle;
                end
            endcase
        end
    end

    // datapath, follows the sequencer
    always_ff @(posedge clk) begin
        if (state == st_idle && frame_start) begin
            means_q <= means;
        end
        if (state == st_load) begin
            // green mean times 256 over the channel mean
            rem     <= '0;
            quo     <= {means_q.g, 8'd0};
            divisor <= div_sel;
        end else if (state == st_run) begin
            rem <= rem_next;
            quo <= quo_next;
            if (cnt == 5'(div_steps - 1)) begin
                case (ch)
                    2'd0:    acc.r <= quo_next;
                    2'd1:    acc.g <= quo_next;
                    default: acc.b <= quo_next;
                endcase
            end
        end
    end

    // stats adds one to every mean, so zero means a broken mean path
    a_divisor_nonzero: assert property (
        @(posedge clk) disable iff (!reset_n)
        state == st_load |-> div_sel != '0
    );

    // frame too short for the divider, this start gets dropped
    a_start_when_idle: assert property (
        @(posedge clk) disable iff (!reset_n)
        frame_start |-> state == st_idle
    );

endmodule

//--- hw/awb_gain_apply.sv
module awb_gain_apply import awb_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  video_t vid_s1,
    input  gains_t gains,
    output video_t vid_out
);

    // full product width, pixel times gain
    localparam int prod_w = pix_w + gain_w;

    // stage two register contents
    typedef struct packed {
        logic              vsync;
        logic              hsync;
        logic              den;
        logic [prod_w-1:0] r;
        logic [prod_w-1:0] g;
        logic [prod_w-1:0] b;
    } prod_t;

    prod_t s2;
    rgb_t  clipped;

    // drop the fraction and saturate to the pixel range
    function automatic logic [pix_w-1:0] clip(input logic [prod_w-1:0] p);
        logic [prod_w-9:0] whole;
        whole = p[prod_w-1:8];
        if (whole > prod_w'(255)) begin
            return '1;
        end
        return whole[pix_w-1:0];
    endfunction

    // stage two sync bits
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s2.vsync <= 1'b0;
            s2.hsync <= 1'b0;
            s2.den   <= 1'b0;
        end else begin
            s2.vsync <= vid_s1.vsync;
            s2.hsync <= vid_s1.hsync;
            s2.den   <= vid_s1.den;
        end
    end

    // stage two products
    always_ff @(posedge clk) begin
        s2.r <= prod_w'(vid_s1.pix.r) * prod_w'(gains.r);
        s2.g <= prod_w'(vid_s1.pix.g) * prod_w'(gains.g);
        s2.b <= prod_w'(vid_s1.pix.b) * prod_w'(gains.b);
    end

    assign clipped.r = clip(s2.r);
    assign clipped.g = clip(s2.g);
    assign clipped.b = clip(s2.b);

    // stage three output
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vid_out <= '0;
        end else begin
            vid_out.vsync <= s2.vsync;
            vid_out.hsync <= s2.hsync;
            vid_out.den   <= s2.den;
            vid_out.pix   <= clipped;
        end
    end

endmodule

//--- hw/awb_top.sv
module awb_top import awb_pkg::*; #(
    parameter int stat_shift = 16
) (
    input  logic   clk,
    input  logic   reset_n,
    input  video_t vid_in,
    output video_t vid_out
);

    video_t vid_s1;
    logic   frame_start;
    means_t means;
    gains_t gains;
    logic   gains_valid;

    // frame statistics, first pipeline stage
    awb_stats #(
        .stat_shift (stat_shift)
    ) u_stats (
        .clk         (clk),
        .reset_n     (reset_n),
        .vid_in      (vid_in),
        .vid_s1      (vid_s1),
        .frame_start (frame_start),
        .means       (means)
    );

    // gains from the previous frame's means
    awb_gain_divider u_divider (
        .clk         (clk),
        .reset_n     (reset_n),
        .frame_start (frame_start),
        .means       (means),
        .gains       (gains),
        .gains_valid (gains_valid)
    );

    // stages two and three
    awb_gain_apply u_apply (
        .clk     (clk),
        .reset_n (reset_n),
        .vid_s1  (vid_s1),
        .gains   (gains),
        .vid_out (vid_out)
    );

    // new gains must land in the blanking after vsync rise,
    // never while a pixel is entering the multiplier
    a_gains_in_blank: assert property (
        @(posedge clk) disable iff (!reset_n)
        gains_valid |=> !vid_s1.den
    );

endmodule

//--- tb/awb_checker.sv
module awb_checker import awb_pkg::*; (
    input  logic   clk,
    input  logic   reset_n,
    input  video_t vid_in,
    input  video_t vid_out,
    input  rgb_t   exp_pix,
    input  logic   exp_valid,
    output int     frames_checked,
    output int     frames_failed,
    output int     error_count
);

    timeunit 1ns;
    timeprecision 1ps;

    // expected pixels in input order
    rgb_t       exp_q[$];
    // input syncs, three cycles deep
    logic [2:0] sync_hist[3];
    logic       vsync_prev;
    int         frame_errors;
    int         frame_pixels;

    function automatic logic [2:0] sync_bits(input video_t v);
        return {v.vsync, v.hsync, v.den};
    endfunction

    task automatic count_error(input int n);
        frame_errors += n;
        error_count  += n;
    endtask

    task automatic compare_channel(input string name, input logic [pix_w-1:0] got,
                                   input logic [pix_w-1:0] want);
        if (got !== want) begin
            $display("Fail at %0t: channel %s got %0d expected %0d", $time, name, got, want);
            count_error(1);
        end
    endtask

    // one result line per frame
    task automatic close_frame();
        if (exp_q.size() != 0) begin
            $display("frame %0d is missing %0d output pixels", frames_checked + 1, exp_q.size());
            count_error(exp_q.size());
            exp_q.delete();
        end
        if (frame_errors == 0) begin
            $display("frame %0d ok, %0d pixels matched", frames_checked + 1, frame_pixels);
        end else begin
            $display("frame %0d bad, %0d errors", frames_checked + 1, frame_errors);
            frames_failed++;
        end
        frame_errors = 0;
        frame_pixels = 0;
        frames_checked++;
    endtask

    // negedge sampling, inputs and outputs both settled
    always @(negedge clk) begin
        rgb_t want;
        if (!reset_n) begin
            if (vid_out !== '0) begin
                $display("Fail at %0t: vid_out %h during reset, expected 0", $time, vid_out);
                count_error(1);
            end
            sync_hist[0] = '0;
            sync_hist[1] = '0;
            sync_hist[2] = '0;
            vsync_prev   = 1'b0;
        end else begin
            // syncs must trail the input by three cycles
            if (sync_bits(vid_out) !== sync_hist[2]) begin
                $display("Fail at %0t: syncs got %b expected %b", $time,
                         sync_bits(vid_out), sync_hist[2]);
                count_error(1);
            end
            sync_hist[2] = sync_hist[1];
            sync_hist[1] = sync_hist[0];
            sync_hist[0] = sync_bits(vid_in);
            if (vid_out.den === 1'b1) begin
                if (exp_q.size() == 0) begin
                    $display("surplus output pixel at %0t with nothing expected", $time);
                    count_error(1);
                end else begin
                    want = exp_q.pop_front();
                    compare_channel("r", vid_out.pix.r, want.r);
                    compare_channel("g", vid_out.pix.g, want.g);
                    compare_channel("b", vid_out.pix.b, want.b);
                    frame_pixels++;
                end
            end
            // queue after compare, a new pixel is never its own output
            if (exp_valid) begin
                exp_q.push_back(exp_pix);
            end
            if (vsync_prev && !vid_out.vsync) begin
                close_frame();
            end
            vsync_prev = vid_out.vsync;
        end
    end

endmodule

//--- tb/awb_tb.sv
module awb_tb import awb_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // cycles any single wait may take
    localparam int wait_limit = 2000;

    logic   clk;
    logic   reset_n;
    video_t vid_in;
    video_t vid_out;
    rgb_t   exp_pix;
    logic   exp_valid;
    int     frames_checked;
    int     frames_failed;
    int     error_count;
    int     frames_sent;
    bit     run_error;

    // 40 ns period
    always #20 clk = ~clk;

    awb_top #(
        .stat_shift (2)
    ) dut (
        .clk     (clk),
        .reset_n (reset_n),
        .vid_in  (vid_in),
        .vid_out (vid_out)
    );

    awb_checker u_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .vid_in         (vid_in),
        .vid_out        (vid_out),
        .exp_pix        (exp_pix),
        .exp_valid      (exp_valid),
        .frames_checked (frames_checked),
        .frames_failed  (frames_failed),
        .error_count    (error_count)
    );

    // one video beat, applied just after the rising edge
    task automatic send_beat(input logic vs, input logic hs, input logic de,
                             input rgb_t p, input logic ev, input rgb_t e);
        @(posedge clk);
        #2;
        vid_in.vsync = vs;
        vid_in.hsync = hs;
        vid_in.den   = de;
        vid_in.pix   = p;
        exp_valid    = ev;
        exp_pix      = e;
    endtask

    // blank beat, syncs only
    task automatic idle_beat(input logic vs, input logic hs);
        send_beat(vs, hs, 1'b0, '0, 1'b0, '0);
    endtask

    // pixel idx of a 4 by 4 frame, random gaps inside a line
    task automatic send_pixel(input int idx, input rgb_t p, input rgb_t e);
        int gap;
        if (idx % 4 != 0) begin
            gap = $urandom_range(3, 0);
            repeat (gap) idle_beat(1'b1, 1'b1);
        end
        send_beat(1'b1, 1'b1, 1'b1, p, 1'b1, e);
        // short horizontal blank after each line
        if (idx % 4 == 3) begin
            repeat (2) idle_beat(1'b1, 1'b0);
        end
    endtask

    // vertical blank, then wait for the checker to close the frame
    task automatic end_frame();
        int cycles;
        repeat (20) idle_beat(1'b0, 1'b0);
        cycles = 0;
        while (frames_checked < frames_sent && cycles < wait_limit) begin
            @(posedge clk);
            cycles++;
        end
        if (frames_checked < frames_sent) begin
            $display("timeout: frame %0d never closed at the output", frames_sent);
            run_error = 1'b1;
        end
    endtask

    initial begin
        int         fd;
        int         n;
        int         idx;
        string      line;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
        logic [7:0] er;
        logic [7:0] eg;
        logic [7:0] eb;
        bit         in_frame;
        bit         done;

        clk         = 1'b0;
        reset_n     = 1'b0;
        vid_in      = '0;
        exp_pix     = '0;
        exp_valid   = 1'b0;
        frames_sent = 0;
        run_error   = 1'b0;
        in_frame    = 1'b0;
        done        = 1'b0;
        idx         = 0;
        void'($urandom(32'hb896_2287));

        fd = $fopen("tb/awb_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/awb_trace.txt");
            run_error = 1'b1;
        end

        repeat (16) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // trace walk, one line per step
        while (!done && !run_error) begin
            n = $fgets(line, fd);
            if (n == 0) begin
                $display("trace ended without an E line");
                run_error = 1'b1;
            end else if (line[0] == "#" || line[0] == "\n") begin
                continue;
            end else if (line[0] == "F") begin
                if (in_frame) begin
                    end_frame();
                end
                in_frame = 1'b1;
                idx      = 0;
                frames_sent++;
                // vsync up, long blank for the divider
                repeat (120) idle_beat(1'b1, 1'b0);
            end else if (line[0] == "P") begin
                n = $sscanf(line, "P %h %h %h %h %h %h", r, g, b, er, eg, eb);
                if (n != 6) begin
                    $display("bad pixel line in trace: %s", line);
                    run_error = 1'b1;
                end else begin
                    send_pixel(idx, {r, g, b}, {er, eg, eb});
                    idx++;
                end
            end else if (line[0] == "E") begin
                if (in_frame) begin
                    end_frame();
                end
                done = 1'b1;
            end else begin
                $display("unknown line in trace: %s", line);
                run_error = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("frames passed %0d, frames failed %0d, errors %0d",
                 frames_checked - frames_failed, frames_failed, error_count);
        if (run_error || error_count != 0 || frames_failed != 0 ||
            frames_sent == 0 || frames_checked != frames_sent) begin
            $display("TESTBENCH FAILED");
        end else begin
            $display("TESTBENCH PASSED");
        end
        $finish;
    end

endmodule

//--- tb/awb_trace.txt
# F opens a frame, E ends the trace
# P r g b exp_r exp_g exp_b, all hex
F
P c0 80 40 c0 80 40
P c1 81 41 c1 81 41
P c2 82 42 c2 82 42
P c3 83 43 c3 83 43
P c4 84 44 c4 84 44
P c5 85 45 c5 85 45
P c6 86 46 c6 86 46
P c7 87 47 c7 87 47
P c8 88 48 c8 88 48
P c9 89 49 c9 89 49
P ca 8a 4a ca 8a 4a
P cb 8b 4b cb 8b 4b
P cc 8c 4c cc 8c 4c
P cd 8d 4d cd 8d 4d
P ce 8e 4e ce 8e 4e
P cf 8f 4f cf 8f 4f
F
P 60 90 30 40 90 5d
P 61 91 31 41 91 5e
P 62 92 32 41 92 60
P 63 93 33 42 93 62
P 64 94 34 43 94 64
P 65 95 35 43 95 66
P 66 96 36 44 96 68
P 67 97 37 45 97 6a
P 68 98 38 45 98 6c
P 69 99 39 46 99 6e
P 6a 9a 3a 47 9a 70
P 6b 9b 3b 47 9b 72
P 6c 9c 3c 48 9c 74
P 6d 9d 3d 49 9d 76
P 6e 9e 3e 49 9e 78
P 6f 9f 3f 4a 9f 7a
F
P 40 40 40 5e 40 b6
P 60 60 60 8d 60 ff
P 80 80 80 bd 80 ff
P a0 a0 a0 ec a0 ff
P b0 b0 b0 ff b0 ff
P c0 c0 c0 ff c0 ff
P d0 d0 d0 ff d0 ff
P e0 e0 e0 ff e0 ff
P f0 f0 f0 ff f0 ff
P ff ff ff ff ff ff
P 20 20 20 2f 20 5b
P 10 10 10 17 10 2d
P 90 90 90 d4 90 ff
P ac ac ac fd ac ff
P ad ad ad ff ad ff
P 70 70 70 a5 70 ff
F
P 12 34 56 12 34 56
P 9a bc de 9a bc de
P ff 00 7f ff 00 7f
P 01 fe 80 01 fe 80
P 33 66 99 33 66 99
P c8 c8 c8 c8 c8 c8
P 00 00 00 00 00 00
P ff ff ff ff ff ff
P 7e 81 42 7e 81 42
P 25 b7 e9 25 b7 e9
P 5a a5 3c 5a a5 3c
P d1 2e 90 d1 2e 90
P 88 44 22 88 44 22
P 0f f0 0f 0f f0 0f
P 63 9c 6b 63 9c 6b
P aa 55 ee aa 55 ee
E

//--- all.f
hw/awb_pkg.sv
hw/awb_stats.sv
hw/awb_gain_divider.sv
hw/awb_gain_apply.sv
hw/awb_top.sv
tb/awb_checker.sv
tb/awb_tb.sv

//--- Makefile
# Verilator build of the white balance testbench

SIM = obj_dir/sim_awb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module awb_tb -f all.f -o sim_awb

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TESTBENCH PASSED$$"

clean:
	rm -rf obj_dir
